//--- l2_cache_pkg.sv
package l2_cache_pkg;

    // line geometry
    localparam int line_bits   = 256;
    localparam int offset_bits = 5;

    // one full cache line, the unit of every transfer
    typedef logic [line_bits-1:0] line_t;

    // byte address on both ports
    typedef logic [31:0] addr_t;

    // controller states
    typedef enum logic [1:0] {
        idle,
        write_back,
        allocate,
        respond
    } cache_state_t;

endpackage

//--- line_array.sv
`timescale 1ns/1ps

module line_array #(
    parameter int  idx_bits = 5,
    parameter type entry_t  = logic
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                write,
    input  logic [idx_bits-1:0] index,
    input  entry_t              datain,
    output entry_t              dataout
);

    localparam int num_entries = 1 << idx_bits;

    entry_t entries [num_entries];

    // async read of the indexed set
    assign dataout = entries[index];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // empty and clean after reset
            for (int i = 0; i < num_entries; i++) begin
                entries[i] <= '0;
            end
        end else if (write) begin
            entries[index] <= datain;
        end
    end

endmodule

//--- pseudo_lru.sv
`timescale 1ns/1ps

module pseudo_lru #(
    parameter int way_bits = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_lru,
    input  logic [way_bits-1:0] new_access,
    output logic [way_bits-1:0] lru
);

    localparam int num_ways = 1 << way_bits;

    // node n has children 2n+1 and 2n+2 in heap order
    // a node bit of 0 points the victim to the left subtree
    logic [num_ways-2:0] tree;
    logic [num_ways-2:0] tree_next;

    // walk the path of the accessed way, point each node away from it
    always_comb begin
        int node;
        tree_next = tree;
        node = 0;
        for (int l = 0; l < way_bits; l++) begin
            tree_next[node] = ~new_access[way_bits-1-l];
            node = 2 * node + 1 + int'(new_access[way_bits-1-l]);
        end
    end

    // follow the node bits from the root to the victim
    always_comb begin
        int node;
        lru = '0;
        node = 0;
        for (int l = 0; l < way_bits; l++) begin
            lru[way_bits-1-l] = tree[node];
            node = 2 * node + 1 + int'(tree[node]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tree <= '0;
        end else if (load_lru) begin
            tree <= tree_next;
        end
    end

endmodule

//--- l2cache_datapath.sv
`timescale 1ns/1ps

module l2cache_datapath import l2_cache_pkg::*; #(
    parameter int set_bits = 5,
    parameter int way_bits = 2
) (
    input  logic  clk,
    input  logic  rst_n,
    // request side
    input  addr_t mem_address,
    input  line_t mem_wdata,
    output line_t mem_rdata,
    // memory side
    output addr_t pmem_address,
    output line_t pmem_wdata,
    input  line_t pmem_rdata,
    // strobes from control
    input  logic  way_sel_method,
    input  logic  load_line_data,
    input  logic  load_valid,
    input  logic  load_dirty,
    input  logic  load_lru,
    input  logic  load_wdata_reg,
    input  logic  line_datain_sel,
    input  logic  valid_in,
    input  logic  dirty_in,
    input  logic  address_sel,
    // status to control
    output logic  hit,
    output logic  dirty,
    output logic  valid_lru_way
);

    localparam int tag_bits = $bits(addr_t) - offset_bits - set_bits;
    localparam int num_sets = 1 << set_bits;
    localparam int num_ways = 1 << way_bits;

    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [set_bits-1:0] set_idx_t;
    typedef logic [way_bits-1:0] way_idx_t;

    // address split
    tag_t     tag;
    set_idx_t idx;

    assign tag = mem_address[$bits(addr_t)-1 -: tag_bits];
    assign idx = mem_address[offset_bits +: set_bits];

    // per-way array outputs
    line_t data_way  [num_ways];
    tag_t  tag_way   [num_ways];
    logic [num_ways-1:0] valid_way;
    logic [num_ways-1:0] dirty_way;

    // per-way write enables
    logic [num_ways-1:0] load_data_way;
    logic [num_ways-1:0] load_valid_way;
    logic [num_ways-1:0] load_dirty_way;

    way_idx_t hit_way;
    way_idx_t lru_way;
    way_idx_t way_select;
    line_t    line_datain;
    line_t    victim_line;
    addr_t    write_back_addr;

    // fill from memory, or the full line from the requester
    assign line_datain = line_datain_sel ? mem_wdata : pmem_rdata;

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        line_array #(.idx_bits(set_bits), .entry_t(line_t)) u_data (
            .clk     (clk),
            .rst_n   (rst_n),
            .write   (load_data_way[w]),
            .index   (idx),
            .datain  (line_datain),
            .dataout (data_way[w])
        );

        // tag follows the data write
        line_array #(.idx_bits(set_bits), .entry_t(tag_t)) u_tag (
            .clk     (clk),
            .rst_n   (rst_n),
            .write   (load_data_way[w]),
            .index   (idx),
            .datain  (tag),
            .dataout (tag_way[w])
        );

        line_array #(.idx_bits(set_bits), .entry_t(logic)) u_valid (
            .clk     (clk),
            .rst_n   (rst_n),
            .write   (load_valid_way[w]),
            .index   (idx),
            .datain  (valid_in),
            .dataout (valid_way[w])
        );

        line_array #(.idx_bits(set_bits), .entry_t(logic)) u_dirty (
            .clk     (clk),
            .rst_n   (rst_n),
            .write   (load_dirty_way[w]),
            .index   (idx),
            .datain  (dirty_in),
            .dataout (dirty_way[w])
        );
    end

    // tag compare over all ways
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (valid_way[w] && (tag_way[w] == tag)) begin
                hit = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end
    end

    // one replacement tree per set where only the indexed tree updates
    way_idx_t lru_set [num_sets];

    for (genvar s = 0; s < num_sets; s++) begin : g_set
        pseudo_lru #(.way_bits(way_bits)) u_plru (
            .clk        (clk),
            .rst_n      (rst_n),
            .load_lru   (load_lru && (idx == set_idx_t'(s))),
            .new_access (way_select),
            .lru        (lru_set[s])
        );
    end

    assign lru_way = lru_set[idx];

    // 0 picks the hit way, 1 the victim
    assign way_select = way_sel_method ? lru_way : hit_way;

    // route load strobes to the selected way
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            load_data_way[w]  = load_line_data && (way_select == way_idx_t'(w));
            load_valid_way[w] = load_valid && (way_select == way_idx_t'(w));
            load_dirty_way[w] = load_dirty && (way_select == way_idx_t'(w));
        end
    end

    assign mem_rdata     = data_way[way_select];
    assign dirty         = dirty_way[lru_way];
    assign valid_lru_way = valid_way[lru_way];

    // victim held for the whole write-back
    always_ff @(posedge clk) begin
        if (load_wdata_reg) begin
            victim_line <= data_way[lru_way];
        end
    end

    assign pmem_wdata = victim_line;

    // arrays are not written in write_back so the victim tag holds until the fill
    assign write_back_addr = {tag_way[lru_way], idx, {offset_bits{1'b0}}};

    assign pmem_address = address_sel
        ? write_back_addr
        : {mem_address[$bits(addr_t)-1:offset_bits], {offset_bits{1'b0}}};

endmodule

//--- l2cache_control.sv
`timescale 1ns/1ps

module l2cache_control import l2_cache_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    // requester
    input  logic mem_read,
    input  logic mem_write,
    output logic mem_resp,
    // memory
    input  logic pmem_resp,
    output logic pmem_read,
    output logic pmem_write,
    // datapath status
    input  logic hit,
    input  logic dirty,
    input  logic valid_lru_way,
    // datapath strobes
    output logic way_sel_method,
    output logic load_line_data,
    output logic load_valid,
    output logic load_dirty,
    output logic load_lru,
    output logic load_wdata_reg,
    output logic line_datain_sel,
    output logic valid_in,
    output logic dirty_in,
    output logic address_sel
);

    cache_state_t state;
    cache_state_t next_state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state      = state;
        mem_resp        = 1'b0;
        pmem_read       = 1'b0;
        pmem_write      = 1'b0;
        way_sel_method  = 1'b0;
        load_line_data  = 1'b0;
        load_valid      = 1'b0;
        load_dirty      = 1'b0;
        load_lru        = 1'b0;
        load_wdata_reg  = 1'b0;
        line_datain_sel = 1'b0;
        valid_in        = 1'b0;
        dirty_in        = 1'b0;
        address_sel     = 1'b0;

        case (state)
            idle: begin
                if (mem_read || mem_write) begin
                    if (hit) begin
                        // served in this cycle
                        mem_resp = 1'b1;
                        load_lru = 1'b1;
                        if (mem_write) begin
                            load_line_data  = 1'b1;
                            line_datain_sel = 1'b1;
                            load_dirty      = 1'b1;
                            dirty_in        = 1'b1;
                        end
                    end else begin
                        way_sel_method = 1'b1;
                        if (valid_lru_way && dirty) begin
                            // grab the victim before pmem_write goes up
                            load_wdata_reg = 1'b1;
                            next_state     = write_back;
                        end else begin
                            next_state = allocate;
                        end
                    end
                end
            end

            write_back: begin
                way_sel_method = 1'b1;
                address_sel    = 1'b1;
                pmem_write     = 1'b1;
                if (pmem_resp) begin
                    next_state = allocate;
                end
            end

            allocate: begin
                way_sel_method = 1'b1;
                if (mem_write) begin
                    // the write covers the whole line so nothing is fetched
                    load_line_data  = 1'b1;
                    line_datain_sel = 1'b1;
                    load_valid      = 1'b1;
                    valid_in        = 1'b1;
                    load_dirty      = 1'b1;
                    dirty_in        = 1'b1;
                    load_lru        = 1'b1;
                    next_state      = respond;
                end else begin
                    pmem_read = 1'b1;
                    if (pmem_resp) begin
                        // fetched line lands clean
                        load_line_data = 1'b1;
                        load_valid     = 1'b1;
                        valid_in       = 1'b1;
                        load_dirty     = 1'b1;
                        load_lru       = 1'b1;
                        next_state     = respond;
                    end
                end
            end

            respond: begin
                // the request now hits and reads from the hit way
                mem_resp   = 1'b1;
                next_state = idle;
            end

            default: begin
                next_state = idle;
            end
        endcase
    end

endmodule

//--- l2cache.sv
`timescale 1ns/1ps

module l2cache import l2_cache_pkg::*; #(
    parameter int set_bits = 5,
    parameter int way_bits = 2
) (
    input  logic  clk,
    input  logic  rst_n,
    // L1 side
    input  logic  mem_read,
    input  logic  mem_write,
    input  addr_t mem_address,
    input  line_t mem_wdata,
    output line_t mem_rdata,
    output logic  mem_resp,
    // physical memory side
    input  line_t pmem_rdata,
    input  logic  pmem_resp,
    output addr_t pmem_address,
    output line_t pmem_wdata,
    output logic  pmem_read,
    output logic  pmem_write
);

    logic way_sel_method;
    logic load_line_data;
    logic load_valid;
    logic load_dirty;
    logic load_lru;
    logic load_wdata_reg;
    logic line_datain_sel;
    logic valid_in;
    logic dirty_in;
    logic address_sel;
    logic hit;
    logic dirty;
    logic valid_lru_way;

    l2cache_datapath #(.set_bits(set_bits), .way_bits(way_bits)) u_datapath (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .pmem_address    (pmem_address),
        .pmem_wdata      (pmem_wdata),
        .pmem_rdata      (pmem_rdata),
        .way_sel_method  (way_sel_method),
        .load_line_data  (load_line_data),
        .load_valid      (load_valid),
        .load_dirty      (load_dirty),
        .load_lru        (load_lru),
        .load_wdata_reg  (load_wdata_reg),
        .line_datain_sel (line_datain_sel),
        .valid_in        (valid_in),
        .dirty_in        (dirty_in),
        .address_sel     (address_sel),
        .hit             (hit),
        .dirty           (dirty),
        .valid_lru_way   (valid_lru_way)
    );

    l2cache_control u_control (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_resp        (mem_resp),
        .pmem_resp       (pmem_resp),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .hit             (hit),
        .dirty           (dirty),
        .valid_lru_way   (valid_lru_way),
        .way_sel_method  (way_sel_method),
        .load_line_data  (load_line_data),
        .load_valid      (load_valid),
        .load_dirty      (load_dirty),
        .load_lru        (load_lru),
        .load_wdata_reg  (load_wdata_reg),
        .line_datain_sel (line_datain_sel),
        .valid_in        (valid_in),
        .dirty_in        (dirty_in),
        .address_sel     (address_sel)
    );

endmodule

//--- tb_pmem_model.sv
`timescale 1ns/1ps

module tb_pmem_model import l2_cache_pkg::*; #(
    parameter int delay = 3
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  pmem_read,
    input  logic  pmem_write,
    input  addr_t pmem_address,
    input  line_t pmem_wdata,
    output line_t pmem_rdata,
    output logic  pmem_resp,
    // fetch and write-back log with the last entry and running counts
    output int    rd_count,
    output addr_t rd_addr,
    output int    wb_count,
    output addr_t wb_addr,
    output line_t wb_data
);

    // lines never written hold their own address eight times
    line_t store [addr_t];
    int    wait_cnt;

    function automatic line_t read_line(addr_t a);
        if (store.exists(a)) begin
            return store[a];
        end
        return {8{a}};
    endfunction

    always @(posedge clk) begin
        pmem_resp <= 1'b0;
        if (!rst_n) begin
            wait_cnt   <= 0;
            rd_count   <= 0;
            wb_count   <= 0;
            rd_addr    <= '0;
            wb_addr    <= '0;
            wb_data    <= '0;
            pmem_rdata <= '0;
        end else if ((pmem_read || pmem_write) && !pmem_resp) begin
            if (wait_cnt == delay - 1) begin
                wait_cnt  <= 0;
                pmem_resp <= 1'b1;
                if (pmem_write) begin
                    store[pmem_address] = pmem_wdata;
                    wb_count <= wb_count + 1;
                    wb_addr  <= pmem_address;
                    wb_data  <= pmem_wdata;
                end else begin
                    pmem_rdata <= read_line(pmem_address);
                    rd_count   <= rd_count + 1;
                    rd_addr    <= pmem_address;
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

endmodule

//--- tb_l2cache.sv
`timescale 1ns/1ps

module tb_l2cache import l2_cache_pkg::*; ();

    localparam int set_bits    = 5;
    localparam int way_bits    = 2;
    localparam int num_sets    = 1 << set_bits;
    localparam int num_ways    = 1 << way_bits;
    localparam int tag_bits    = 32 - offset_bits - set_bits;
    localparam int clk_period  = 4;
    localparam int num_entries = 27;
    localparam int timeout_ns  = num_entries * 20 * clk_period;

    typedef enum logic [1:0] {op_read, op_write, op_reset} op_t;

    typedef struct packed {
        op_t         op;
        logic [15:0] tag;
        logic [7:0]  set_idx;
        logic        rand_data;
    } stim_t;

    logic  clk;
    logic  rst_n       = 1'b0;
    logic  mem_read    = 1'b0;
    logic  mem_write   = 1'b0;
    addr_t mem_address = '0;
    line_t mem_wdata   = '0;
    line_t mem_rdata;
    logic  mem_resp;
    addr_t pmem_address;
    line_t pmem_wdata;
    line_t pmem_rdata;
    logic  pmem_read;
    logic  pmem_write;
    logic  pmem_resp;
    int    rd_count;
    int    wb_count;
    addr_t rd_addr;
    addr_t wb_addr;
    line_t wb_data;

    // set 4 and set 5 carry the eviction and write-back sequences
    stim_t stim_table [num_entries] = '{
        '{op_read,  16'd1, 8'd0, 1'b0},
        '{op_read,  16'd2, 8'd1, 1'b0},
        '{op_read,  16'd1, 8'd0, 1'b0},
        '{op_write, 16'd3, 8'd2, 1'b1},
        '{op_read,  16'd3, 8'd2, 1'b0},
        '{op_write, 16'd1, 8'd0, 1'b1},
        '{op_read,  16'd1, 8'd0, 1'b0},
        '{op_read,  16'd1, 8'd4, 1'b0},
        '{op_write, 16'd2, 8'd4, 1'b1},
        '{op_read,  16'd3, 8'd4, 1'b0},
        '{op_read,  16'd4, 8'd4, 1'b0},
        '{op_read,  16'd5, 8'd4, 1'b0},
        '{op_read,  16'd1, 8'd4, 1'b0},
        '{op_read,  16'd2, 8'd4, 1'b0},
        '{op_write, 16'd1, 8'd5, 1'b1},
        '{op_write, 16'd2, 8'd5, 1'b1},
        '{op_write, 16'd3, 8'd5, 1'b1},
        '{op_write, 16'd4, 8'd5, 1'b0},
        '{op_write, 16'd5, 8'd5, 1'b1},
        '{op_read,  16'd5, 8'd5, 1'b0},
        '{op_read,  16'd1, 8'd0, 1'b0},
        '{op_reset, 16'd0, 8'd0, 1'b0},
        '{op_read,  16'd1, 8'd0, 1'b0},
        '{op_read,  16'd2, 8'd4, 1'b0},
        '{op_read,  16'd1, 8'd5, 1'b0},
        '{op_read,  16'd3, 8'd2, 1'b0},
        '{op_read,  16'd2, 8'd4, 1'b0}
    };

    // reference cache state and memory image
    logic [tag_bits-1:0] ref_tag   [num_sets][num_ways];
    bit                  ref_valid [num_sets][num_ways];
    bit                  ref_dirty [num_sets][num_ways];
    line_t               ref_data  [num_sets][num_ways];
    bit [num_ways-2:0]   ref_tree  [num_sets];
    line_t               ref_mem   [addr_t];

    l2cache #(.set_bits(set_bits), .way_bits(way_bits)) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write)
    );

    tb_pmem_model #(.delay(3)) u_pmem (
        .clk          (clk),
        .rst_n        (rst_n),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .rd_count     (rd_count),
        .rd_addr      (rd_addr),
        .wb_count     (wb_count),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic stop_run(string why);
        $display("CHECKS FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_line(string name, line_t got, line_t exp);
        if (got !== exp) begin
            $display("error: time %0t, %s: got %h, expected %h", $time, name, got, exp);
            stop_run({name, " mismatch"});
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("error: time %0t, %s: got %h, expected %h", $time, name, got, exp);
            stop_run({name, " mismatch"});
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("error: time %0t, %s: got %b, expected %b", $time, name, got, exp);
            stop_run({name, " mismatch"});
        end
    endtask

    function automatic line_t mem_line(addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return {8{a}};
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int k = 0; k < 8; k++) begin
            l[32*k +: 32] = $urandom();
        end
        return l;
    endfunction

    // each node bit from the root picks the subtree holding the victim
    function automatic int victim_of(int s);
        int p;
        p = 0;
        for (int lvl = 0; lvl < way_bits; lvl++) begin
            p = 2 * p + int'(ref_tree[s][(1 << lvl) - 1 + p]);
        end
        return p;
    endfunction

    // nodes above the used way now point to the other side
    task automatic touch(int s, int w);
        int dir;
        int node;
        for (int lvl = 0; lvl < way_bits; lvl++) begin
            dir = (w >> (way_bits - 1 - lvl)) & 1;
            node = (1 << lvl) - 1 + (w >> (way_bits - lvl));
            ref_tree[s][node] = (dir == 0);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int s = 0; s < num_sets; s++) begin
            ref_tree[s] = '0;
            for (int w = 0; w < num_ways; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end
    endtask

    task automatic run_request(op_t op, addr_t addr, line_t wdata);
        int                  s;
        int                  hw;
        int                  rd_before;
        int                  wb_before;
        logic [tag_bits-1:0] t;
        addr_t               line_addr;
        addr_t               exp_wb_addr;
        line_t               exp_wb_data;
        line_t               got_rdata;
        bit                  exp_fetch;
        bit                  exp_wb;
        s = int'(addr[offset_bits +: set_bits]);
        t = addr[31 -: tag_bits];
        line_addr = {addr[31:offset_bits], {offset_bits{1'b0}}};
        exp_fetch = 1'b0;
        exp_wb = 1'b0;
        exp_wb_addr = '0;
        exp_wb_data = '0;
        hw = -1;
        for (int w = 0; w < num_ways; w++) begin
            if (ref_valid[s][w] && ref_tag[s][w] == t) begin
                hw = w;
            end
        end
        if (hw < 0) begin
            hw = victim_of(s);
            if (ref_valid[s][hw] && ref_dirty[s][hw]) begin
                exp_wb = 1'b1;
                exp_wb_addr = {ref_tag[s][hw], addr[offset_bits +: set_bits],
                               {offset_bits{1'b0}}};
                exp_wb_data = ref_data[s][hw];
                ref_mem[exp_wb_addr] = exp_wb_data;
            end
            ref_valid[s][hw] = 1'b1;
            ref_dirty[s][hw] = 1'b0;
            ref_tag[s][hw] = t;
            if (op == op_read) begin
                exp_fetch = 1'b1;
                ref_data[s][hw] = mem_line(line_addr);
            end
        end
        if (op == op_write) begin
            ref_data[s][hw] = wdata;
            ref_dirty[s][hw] = 1'b1;
        end
        touch(s, hw);

        rd_before = rd_count;
        wb_before = wb_count;
        @(posedge clk);
        mem_read    <= (op == op_read);
        mem_write   <= (op == op_write);
        mem_address <= addr;
        mem_wdata   <= wdata;
        do @(posedge clk); while (mem_resp !== 1'b1);
        got_rdata = mem_rdata;
        mem_read  <= 1'b0;
        mem_write <= 1'b0;

        if (op == op_read) begin
            check_line("mem_rdata", got_rdata, ref_data[s][hw]);
        end
        check_bit("pmem_read", rd_count != rd_before, exp_fetch);
        check_bit("pmem_read count at most one", (rd_count - rd_before) <= 1, 1'b1);
        if (exp_fetch) begin
            check_addr("pmem_address on fetch", rd_addr, line_addr);
        end
        check_bit("pmem_write", wb_count != wb_before, exp_wb);
        check_bit("pmem_write count at most one", (wb_count - wb_before) <= 1, 1'b1);
        if (exp_wb) begin
            check_addr("pmem_address on write-back", wb_addr, exp_wb_addr);
            check_line("pmem_wdata", wb_data, exp_wb_data);
        end
    endtask

    initial begin
        stim_t       e;
        addr_t       addr;
        line_t       wdata;
        void'($urandom(32'hf350_d1a9));
        apply_reset();
        for (int i = 0; i < num_entries; i++) begin
            e = stim_table[i];
            if (e.op == op_reset) begin
                apply_reset();
            end else begin
                addr = (addr_t'(e.tag) << (offset_bits + set_bits))
                     | (addr_t'(e.set_idx) << offset_bits);
                wdata = e.rand_data ? random_line() : {8{~addr}};
                run_request(e.op, addr, wdata);
            end
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // watchdog
    initial begin
        cache_state_t st;
        #(timeout_ns);
        st = UUT.u_control.state;
        $display("request never answered, controller in state %s", st.name());
        stop_run("request never answered");
    end

endmodule

//--- files.f
l2_cache_pkg.sv
line_array.sv
pseudo_lru.sv
l2cache_datapath.sv
l2cache_control.sv
l2cache.sv
tb_pmem_model.sv
tb_l2cache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the L2 cache testbench, exit status follows the simulation
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_l2cache \
    -f files.f \
    -o sim_l2cache

./obj_dir/sim_l2cache
